//--- design/fetch_pkg.sv
package fetch_pkg;

	// First fetch after reset
	localparam logic [31:0] reset_vector = 32'h0000_0000;

	// Direct-mapped cache geometry, one word per line
	localparam int icache_index_bits = 4;
	localparam int icache_lines = 1 << icache_index_bits;
	localparam int icache_tag_bits = 32 - icache_index_bits - 2;

	// RV32I major opcodes
	localparam logic [6:0] op_lui      = 7'b0110111;
	localparam logic [6:0] op_auipc    = 7'b0010111;
	localparam logic [6:0] op_jal      = 7'b1101111;
	localparam logic [6:0] op_jalr     = 7'b1100111;
	localparam logic [6:0] op_branch   = 7'b1100011;
	localparam logic [6:0] op_load     = 7'b0000011;
	localparam logic [6:0] op_store    = 7'b0100011;
	localparam logic [6:0] op_op_imm   = 7'b0010011;
	localparam logic [6:0] op_op       = 7'b0110011;
	localparam logic [6:0] op_misc_mem = 7'b0001111;
	localparam logic [6:0] op_system   = 7'b1110011;

	// Whole-word encodings of the system instructions that stop fetch
	localparam logic [31:0] instr_ecall = 32'h0000_0073;
	localparam logic [31:0] instr_mret  = 32'h3020_0073;
	localparam logic [31:0] instr_wfi   = 32'h1050_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_view_t;

	// Same word, register-format and upper-immediate layouts
	typedef union packed {
		r_view_t r_view;
		u_view_t u_view;
	} instruction_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic       is_control;
	} predecode_t;

	typedef struct packed {
		logic [7:0]   tag;
		logic [31:0]  pc;
		instruction_t instruction;
		logic [4:0]   rs1;
		logic [4:0]   rs2;
		logic [4:0]   rd;
		logic         is_control;
	} fetch_data_t;

endpackage

//--- design/instruction_cache.sv
`timescale 1ns/1ps

module instruction_cache (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [31:0] i_pc,
	input  logic        i_stall,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	typedef enum logic {
		st_lookup,
		st_refill
	} cache_state_t;

	logic [31:0] data_array [fetch_pkg::icache_lines];
	logic [fetch_pkg::icache_tag_bits-1:0] tag_array [fetch_pkg::icache_lines];
	logic [fetch_pkg::icache_lines-1:0] valid;

	cache_state_t state;
	logic ready_q;
	logic [31:0] ready_pc;
	logic [fetch_pkg::icache_index_bits-1:0] index;
	logic [fetch_pkg::icache_index_bits-1:0] fill_index;
	logic [fetch_pkg::icache_tag_bits-1:0] tag;
	logic hit;
	logic lookup_en;

	assign index = i_pc[fetch_pkg::icache_index_bits+1:2];
	assign tag = i_pc[31:fetch_pkg::icache_index_bits+2];
	assign fill_index = o_bus_address[fetch_pkg::icache_index_bits+1:2];
	assign hit = valid[index] && (tag_array[index] == tag);

	// No lookup in the cycle a word is handed over
	assign lookup_en = (state == st_lookup) && !i_stall && !o_ready;

	// Drop a result whose PC was redirected underneath it
	assign o_ready = ready_q && !i_stall && (i_pc == ready_pc);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= st_lookup;
			valid <= '0;
			ready_q <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			case (state)
				st_lookup: begin
					if (lookup_en) begin
						if (hit) begin
							ready_q <= 1'b1;
						end else begin
							state <= st_refill;
							o_bus_request <= 1'b1;
						end
					end
				end
				st_refill: begin
					// Back to lookup, which then hits on the new line
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						valid[fill_index] <= 1'b1;
						state <= st_lookup;
					end
				end
				default: state <= st_lookup;
			endcase
		end
	end

	// Arrays and read data
	always_ff @(posedge i_clock) begin
		if (lookup_en) begin
			o_rdata <= data_array[index];
			ready_pc <= i_pc;
			if (!hit) begin
				o_bus_address <= {i_pc[31:2], 2'b00};
			end
		end
		if (state == st_refill && i_bus_ready) begin
			data_array[fill_index] <= i_bus_rdata;
			tag_array[fill_index] <= o_bus_address[31:fetch_pkg::icache_index_bits+2];
		end
	end

	// Bus request held with a fixed address until the word arrives
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address));

	// A handed-over word still belongs to a valid line holding its PC
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> valid[ready_pc[fetch_pkg::icache_index_bits+1:2]] &&
			(tag_array[ready_pc[fetch_pkg::icache_index_bits+1:2]] ==
			ready_pc[31:fetch_pkg::icache_index_bits+2]) &&
			(o_rdata == data_array[ready_pc[fetch_pkg::icache_index_bits+1:2]]));

endmodule

//--- design/predecoder.sv
`timescale 1ns/1ps

module predecoder (
	input  fetch_pkg::instruction_t i_instruction,
	output fetch_pkg::predecode_t   o_predecode
);

	logic [6:0] opcode;
	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_system;
	logic stops_fetch;

	assign opcode = i_instruction.r_view.opcode;

	// Format classification
	always_comb begin
		is_r = 1'b0;
		is_i = 1'b0;
		is_s = 1'b0;
		is_b = 1'b0;
		is_u = 1'b0;
		is_j = 1'b0;
		is_system = 1'b0;
		case (opcode)
			fetch_pkg::op_op: is_r = 1'b1;
			fetch_pkg::op_load,
			fetch_pkg::op_op_imm,
			fetch_pkg::op_jalr,
			fetch_pkg::op_misc_mem: is_i = 1'b1;
			fetch_pkg::op_store: is_s = 1'b1;
			fetch_pkg::op_branch: is_b = 1'b1;
			fetch_pkg::op_lui,
			fetch_pkg::op_auipc: is_u = 1'b1;
			fetch_pkg::op_jal: is_j = 1'b1;
			fetch_pkg::op_system: is_system = 1'b1;
			default: ;
		endcase
	end

	// ECALL, MRET and WFI need the whole word, not just the opcode
	assign stops_fetch = is_system && ((i_instruction == fetch_pkg::instr_ecall) ||
		(i_instruction == fetch_pkg::instr_mret) ||
		(i_instruction == fetch_pkg::instr_wfi));

	always_comb begin
		o_predecode.rs1 = (is_r || is_i || is_s || is_b) ? i_instruction.r_view.rs1 : 5'd0;
		o_predecode.rs2 = (is_r || is_s || is_b) ? i_instruction.r_view.rs2 : 5'd0;
		if (is_u || is_j) begin
			o_predecode.rd = i_instruction.u_view.rd;
		end else if (is_r || is_i) begin
			o_predecode.rd = i_instruction.r_view.rd;
		end else begin
			o_predecode.rd = 5'd0;
		end
		o_predecode.is_control = is_j || is_b || (opcode == fetch_pkg::op_jalr) || stops_fetch;
	end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_jump,
	input  logic [31:0]              i_jump_pc,
	input  logic                     i_irq_pending,
	input  logic [31:0]              i_irq_pc,
	output logic                     o_irq_dispatched,
	output logic [31:0]              o_irq_epc,
	output logic [31:0]              o_pc,
	output logic                     o_stall,
	input  fetch_pkg::instruction_t  i_rdata,
	input  logic                     i_ready,
	input  fetch_pkg::predecode_t    i_predecode,
	input  logic                     i_decode_busy,
	output fetch_pkg::fetch_data_t   o_data
);

	typedef enum logic {
		st_wait_icache,
		st_wait_jump
	} fetch_state_t;

	fetch_state_t state;
	logic dispatch;
	logic capture;

	assign o_stall = i_decode_busy || (state != st_wait_icache);

	// One dispatch per pulse; a pending line still high afterwards retriggers
	assign dispatch = (state == st_wait_icache) && i_irq_pending && !o_irq_dispatched;

	// Interrupts win over an arriving word
	assign capture = (state == st_wait_icache) && !i_irq_pending && i_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= st_wait_icache;
			o_pc <= fetch_pkg::reset_vector;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_irq_dispatched <= dispatch;
			case (state)
				st_wait_icache: begin
					if (dispatch) begin
						o_pc <= i_irq_pc;
					end else if (capture) begin
						// Control transfers stop fetch until a jump arrives
						if (i_predecode.is_control) begin
							state <= st_wait_jump;
						end else begin
							o_pc <= o_pc + 32'd4;
						end
					end
				end
				st_wait_jump: begin
					if (i_jump) begin
						o_pc <= i_jump_pc;
						state <= st_wait_icache;
					end
				end
				default: state <= st_wait_icache;
			endcase
		end
	end

	// Record to decode and saved exception PC
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data.tag <= 8'd0;
		end else if (capture) begin
			o_data.tag <= o_data.tag + 8'd1;
		end
		if (capture) begin
			o_data.pc <= o_pc;
			o_data.instruction <= i_rdata;
			o_data.rs1 <= i_predecode.rs1;
			o_data.rs2 <= i_predecode.rs2;
			o_data.rd <= i_predecode.rd;
			o_data.is_control <= i_predecode.is_control;
		end
		if (dispatch) begin
			o_irq_epc <= o_pc;
		end
	end

	// Words arrive from the cache only while the stage accepts them
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |-> !o_stall);

endmodule

//--- design/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_jump,
	input  logic [31:0]            i_jump_pc,
	input  logic                   i_irq_pending,
	input  logic [31:0]            i_irq_pc,
	output logic                   o_irq_dispatched,
	output logic [31:0]            o_irq_epc,
	output logic                   o_bus_request,
	output logic [31:0]            o_bus_address,
	input  logic                   i_bus_ready,
	input  logic [31:0]            i_bus_rdata,
	input  logic                   i_decode_busy,
	output fetch_pkg::fetch_data_t o_data
);

	logic [31:0] pc;
	logic stall;
	logic cache_ready;
	fetch_pkg::instruction_t cache_rdata;
	fetch_pkg::predecode_t predecode;

	instruction_cache instruction_cache_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(stall),
		.o_rdata(cache_rdata),
		.o_ready(cache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Register fields straight off the cache output
	predecoder predecoder_inst (
		.i_instruction(cache_rdata),
		.o_predecode(predecode)
	);

	fetch_stage fetch_stage_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(pc),
		.o_stall(stall),
		.i_rdata(cache_rdata),
		.i_ready(cache_ready),
		.i_predecode(predecode),
		.i_decode_busy(i_decode_busy),
		.o_data(o_data)
	);

endmodule

//--- bench/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_jump,
	input  logic [31:0]            i_jump_pc,
	input  logic [31:0]            i_irq_pc,
	input  logic                   i_irq_dispatched,
	input  logic [31:0]            i_irq_epc,
	input  fetch_pkg::fetch_data_t i_data,
	output int                     o_errors,
	output int                     o_records
);

	logic [31:0] exp_pc;
	logic [31:0] exp_word;
	logic [7:0] last_tag;
	logic waiting_jump;
	logic [31:0] jump_target;
	int jumps_seen;
	int jumps_handled;
	logic [15:0] exp_fields;
	logic [15:0] got_fields;

	// Program image as the memory model holds it
	function automatic logic [31:0] program_word(input logic [31:0] a);
		case (a)
			32'h00: return 32'h123450B7;
			32'h04: return 32'h00508113;
			32'h08: return 32'h002081B3;
			32'h0C: return 32'h00312223;
			32'h10: return 32'h00012203;
			32'h14: return 32'h00001297;
			32'h18: return 32'h00208463;
			32'h40: return 32'h00138393;
			32'h44: return 32'h00238433;
			32'h48: return 32'hFF9FF0EF;
			32'h80: return 32'h00100313;
			32'h84: return 32'h00000073;
			default: return {a[31:20] ^ a[13:2], a[19:15] ^ a[6:2], 2'b00, a[14],
				a[11:7], 7'b0010011};
		endcase
	endfunction

	// Register fields and control flag as {rs1, rs2, rd, is_control}
	function automatic logic [15:0] fields_of(input logic [31:0] w);
		logic [6:0] op;
		logic r;
		logic i;
		logic s;
		logic b;
		logic u;
		logic j;
		logic ctl;
		op = w[6:0];
		r = (op == 7'b0110011);
		i = (op == 7'b0000011) || (op == 7'b0010011) || (op == 7'b1100111) ||
			(op == 7'b0001111);
		s = (op == 7'b0100011);
		b = (op == 7'b1100011);
		u = (op == 7'b0110111) || (op == 7'b0010111);
		j = (op == 7'b1101111);
		ctl = j || b || (op == 7'b1100111) || (w == 32'h00000073) ||
			(w == 32'h30200073) || (w == 32'h10500073);
		return {(r || i || s || b) ? w[19:15] : 5'd0,
			(r || s || b) ? w[24:20] : 5'd0,
			(r || i || u || j) ? w[11:7] : 5'd0,
			ctl};
	endfunction

	initial begin
		o_errors = 0;
		o_records = 0;
		jumps_seen = 0;
		jumps_handled = 0;
		jump_target = '0;
	end

	// Inputs are stable at the rising edge
	always @(posedge i_clock) begin
		if (!i_reset && i_jump) begin
			jump_target <= i_jump_pc;
			jumps_seen <= jumps_seen + 1;
		end
	end

	// Registered outputs settle before the falling edge
	always @(negedge i_clock) begin
		if (i_reset) begin
			exp_pc = fetch_pkg::reset_vector;
			last_tag = 8'd0;
			waiting_jump = 1'b0;
			jumps_handled = jumps_seen;
		end else begin
			if (jumps_handled != jumps_seen) begin
				jumps_handled = jumps_seen;
				exp_pc = jump_target;
				waiting_jump = 1'b0;
			end
			if (i_irq_dispatched) begin
				if (i_irq_epc !== exp_pc) begin
					$display("Mismatch at %0t: epc %h, expected %h", $time, i_irq_epc, exp_pc);
					o_errors = o_errors + 1;
				end
				exp_pc = i_irq_pc;
			end
			if (i_data.tag !== last_tag) begin
				o_records = o_records + 1;
				exp_word = program_word(exp_pc);
				exp_fields = fields_of(exp_word);
				if (i_data.tag !== last_tag + 8'd1) begin
					$display("Mismatch at %0t: tag %0d after %0d", $time, i_data.tag, last_tag);
					o_errors = o_errors + 1;
				end
				if (waiting_jump) begin
					$display("Record at %0t arrived after a control transfer with no jump", $time);
					o_errors = o_errors + 1;
				end
				if (i_data.pc !== exp_pc) begin
					$display("Mismatch at %0t: pc %h, expected %h", $time, i_data.pc, exp_pc);
					o_errors = o_errors + 1;
				end
				if (i_data.instruction !== exp_word) begin
					$display("Mismatch at %0t: instruction %h at pc %h, expected %h", $time,
						i_data.instruction, exp_pc, exp_word);
					o_errors = o_errors + 1;
				end
				got_fields = {i_data.rs1, i_data.rs2, i_data.rd, i_data.is_control};
				if (got_fields !== exp_fields) begin
					$display("Mismatch at %0t: fields %h at pc %h, expected %h", $time,
						got_fields, exp_pc, exp_fields);
					o_errors = o_errors + 1;
				end
				last_tag = i_data.tag;
				waiting_jump = exp_fields[0];
				exp_pc = exp_pc + 32'd4;
			end
		end
	end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	localparam int act_run = 0;
	localparam int act_busy = 1;
	localparam int act_jump = 2;
	localparam int act_irq = 3;
	localparam int wait_limit = 400;
	localparam int jump_hold = 10;

	typedef struct {
		int          action;
		logic [31:0] addr;
		int          count;
		logic [31:0] first_pc;
		bit          reuse;
		string       name;
	} row_t;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic i_decode_busy;
	fetch_pkg::fetch_data_t o_data;

	int checker_errors;
	int checker_records;
	int fails;
	int failed_tests;
	int bus_requests;
	bit timed_out;
	row_t rows[$];
	logic [31:0] mem [64];
	logic [31:0] rand_state;
	bit bus_active;
	int bus_delay;

	instruction_fetch instruction_fetch_inst (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_jump(i_jump), .i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending), .i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched), .o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request), .o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy), .o_data(o_data)
	);

	fetch_checker checker_inst (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_jump(i_jump), .i_jump_pc(i_jump_pc), .i_irq_pc(i_irq_pc),
		.i_irq_dispatched(o_irq_dispatched), .i_irq_epc(o_irq_epc),
		.i_data(o_data), .o_errors(checker_errors), .o_records(checker_records)
	);

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[31:20] ^ a[13:2], a[19:15] ^ a[6:2], 2'b00, a[14], a[11:7], 7'b0010011};
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (a < 32'd256) begin
			return mem[a[7:2]];
		end
		return fill_word(a);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_row(input int action, input logic [31:0] addr, input int count,
		input logic [31:0] first_pc, input bit reuse, input string name);
		row_t r;
		r.action = action;
		r.addr = addr;
		r.count = count;
		r.first_pc = first_pc;
		r.reuse = reuse;
		r.name = name;
		rows.push_back(r);
	endtask

	// Counts new tags from start_tag, keeps the pc of the first one
	task automatic wait_records(input logic [7:0] start_tag, input int n,
		output logic [31:0] first_pc);
		int seen;
		int cycles;
		logic [7:0] last;
		seen = 0;
		cycles = 0;
		last = start_tag;
		first_pc = '0;
		while (seen < n && !timed_out) begin
			@(negedge i_clock);
			cycles++;
			if (o_data.tag != last) begin
				if (seen == 0) begin
					first_pc = o_data.pc;
				end
				seen++;
				last = o_data.tag;
			end
			if (cycles > wait_limit) begin
				$display("Timeout at %0t while waiting for %0d new records", $time, n);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [7:0] start_tag;
		logic [31:0] first_pc;
		int req_before;
		int cycles;
		req_before = bus_requests;
		start_tag = o_data.tag;
		cycles = 0;
		case (r.action)
			act_busy: begin
				i_decode_busy = 1'b1;
				repeat (r.count) begin
					@(negedge i_clock);
					if (o_data.tag != start_tag) begin
						$display("Mismatch at %0t: tag changed while decode busy", $time);
						fails++;
					end
				end
				i_decode_busy = 1'b0;
			end
			act_jump: begin
				while (!o_data.is_control && !timed_out) begin
					@(negedge i_clock);
					cycles++;
					if (cycles > wait_limit) begin
						$display("Timeout at %0t while waiting for a control record", $time);
						timed_out = 1'b1;
					end
				end
				// Hold the jump back so a fetch past the control record would show
				repeat (jump_hold) @(negedge i_clock);
				i_jump = 1'b1;
				i_jump_pc = r.addr;
				@(negedge i_clock);
				i_jump = 1'b0;
			end
			act_irq: begin
				i_irq_pending = 1'b1;
				i_irq_pc = r.addr;
				while (!o_irq_dispatched && !timed_out) begin
					@(negedge i_clock);
					cycles++;
					if (cycles > wait_limit) begin
						$display("Timeout at %0t while waiting for the irq dispatch", $time);
						timed_out = 1'b1;
					end
				end
				i_irq_pending = 1'b0;
			end
			default: ;
		endcase
		if (r.action != act_busy) begin
			wait_records(start_tag, r.count, first_pc);
			if (!timed_out && first_pc != r.first_pc) begin
				$display("Mismatch at %0t: first pc %h, expected %h", $time, first_pc,
					r.first_pc);
				fails++;
			end
		end
		if (r.reuse && bus_requests != req_before) begin
			$display("Mismatch at %0t: %0d bus requests on a cached loop", $time,
				bus_requests - req_before);
			fails++;
		end
	endtask

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	// Memory model, answers after 1 to 4 cycles
	always @(negedge i_clock) begin
		if (i_reset) begin
			i_bus_ready = 1'b0;
			bus_active = 1'b0;
		end else if (i_bus_ready) begin
			i_bus_ready = 1'b0;
		end else if (o_bus_request) begin
			if (!bus_active) begin
				bus_active = 1'b1;
				rand_state = xorshift(rand_state);
				bus_delay = int'(rand_state[1:0]) + 1;
				bus_requests++;
			end
			bus_delay--;
			if (bus_delay == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = word_at(o_bus_address);
				bus_active = 1'b0;
			end
		end
	end

	initial begin
		int errs_before;
		int errs_now;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_decode_busy = 1'b0;
		rand_state = 32'd4466;
		bus_active = 1'b0;
		bus_delay = 0;
		bus_requests = 0;
		fails = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		errs_before = 0;
		errs_now = 0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = fill_word(32'(i * 4));
		end
		mem[0] = 32'h123450B7;
		mem[1] = 32'h00508113;
		mem[2] = 32'h002081B3;
		mem[3] = 32'h00312223;
		mem[4] = 32'h00012203;
		mem[5] = 32'h00001297;
		mem[6] = 32'h00208463;
		mem[16] = 32'h00138393;
		mem[17] = 32'h00238433;
		mem[18] = 32'hFF9FF0EF;
		mem[32] = 32'h00100313;
		mem[33] = 32'h00000073;

		add_row(act_run, 32'h0, 3, 32'h00, 1'b0, "sequential fetch from reset");
		add_row(act_busy, 32'h0, 10, 32'h00, 1'b0, "decode back-pressure");
		add_row(act_run, 32'h0, 4, 32'h0C, 1'b0, "resume up to branch");
		add_row(act_jump, 32'h40, 3, 32'h40, 1'b0, "jump into loop");
		add_row(act_jump, 32'h40, 3, 32'h40, 1'b1, "loop from cache");
		add_row(act_jump, 32'h100, 2, 32'h100, 1'b0, "jump to far code");
		add_row(act_irq, 32'h80, 2, 32'h80, 1'b0, "interrupt redirect");

		repeat (16) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		foreach (rows[i]) begin
			if (!timed_out) begin
				apply_row(rows[i]);
				// Checker counts only move on falling edges
				@(posedge i_clock);
				errs_now = fails + checker_errors;
				if (timed_out || errs_now != errs_before) begin
					failed_tests++;
					$display("test %0d %s: failed", i, rows[i].name);
				end else begin
					$display("test %0d %s: ok", i, rows[i].name);
				end
				errs_before = errs_now;
				@(negedge i_clock);
			end
		end
		repeat (4) @(posedge i_clock);

		$display("tests %0d, failed %0d, records %0d, bus requests %0d, errors %0d",
			rows.size(), failed_tests, checker_records, bus_requests, fails + checker_errors);
		if (!timed_out && failed_tests == 0 && fails + checker_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- fetch_subsystem.f
design/fetch_pkg.sv
design/instruction_cache.sv
design/predecoder.sv
design/fetch_stage.sv
design/instruction_fetch.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f fetch_subsystem.f --top-module fetch_tb \
	-Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
